//--- dv/ex_tb_model.svh
`ifndef EX_TB_MODEL_SVH
`define EX_TB_MODEL_SVH

// signed less-than by biasing both operands into unsigned range
function automatic logic signed_lt(input word_t a, input word_t b);
    return (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
endfunction

function automatic word_t sra_with_fill(input word_t a, input logic [4:0] sh);
    word_t fill;
    fill = a[31] ? ~(32'hffff_ffff >> sh) : 32'h0;  // ones above the shifted msb
    return (a >> sh) | fill;
endfunction

function automatic word_t alu_result_of(input uop_t uop, input word_t pc, input word_t a,
                                        input word_t b, input word_t imm);
    case (uop)
        UOP_ADD:   return a + b;
        UOP_ADDI:  return a + imm;
        UOP_SUB:   return a + ~b + 32'd1;  // two's complement
        UOP_AND:   return a & b;
        UOP_ANDI:  return a & imm;
        UOP_OR:    return a | b;
        UOP_ORI:   return a | imm;
        UOP_XOR:   return a ^ b;
        UOP_XORI:  return a ^ imm;
        UOP_SLT:   return {31'd0, signed_lt(a, b)};
        UOP_SLTI:  return {31'd0, signed_lt(a, imm)};
        UOP_SLTU:  return {31'd0, a < b};
        UOP_SLTIU: return {31'd0, a < imm};
        UOP_LUI:   return imm;
        UOP_AUIPC: return pc + imm;
        UOP_SLL:   return a << b[4:0];
        UOP_SLLI:  return a << imm[4:0];
        UOP_SRL:   return a >> b[4:0];
        UOP_SRLI:  return a >> imm[4:0];
        UOP_SRA:   return sra_with_fill(a, b[4:0]);
        UOP_SRAI:  return sra_with_fill(a, imm[4:0]);
        default:   return 32'd0;
    endcase
endfunction

function automatic logic is_cond_branch(input uop_t uop);
    return uop inside {UOP_BEQ, UOP_BNE, UOP_BLT, UOP_BGE, UOP_BLTU, UOP_BGEU};
endfunction

function automatic logic is_branch_uop(input uop_t uop);
    return (uop inside {UOP_JAL, UOP_JALR}) || is_cond_branch(uop);
endfunction

function automatic logic resolve_taken(input uop_t uop, input word_t a, input word_t b);
    case (uop)
        UOP_JAL, UOP_JALR: return 1'b1;
        UOP_BEQ:  return a == b;
        UOP_BNE:  return a != b;
        UOP_BLT:  return signed_lt(a, b);
        UOP_BGE:  return !signed_lt(a, b);
        UOP_BLTU: return a < b;
        UOP_BGEU: return a >= b;
        default:  return 1'b0;
    endcase
endfunction

function automatic word_t resolve_target(input uop_t uop, input word_t pc, input word_t a,
                                         input word_t imm);
    if (uop == UOP_JALR)
        return a + imm;
    if (is_branch_uop(uop))
        return pc + imm;  // jal and conditional branches are pc relative
    return 32'd0;
endfunction

// {call, ret, jmp} for the return-address stack
function automatic logic [2:0] classify_ras(input uop_t uop, input reg_addr_t rd,
                                            input reg_addr_t rs1);
    logic rd_l;
    logic rs1_l;
    rd_l  = (rd == REG_RA) || (rd == REG_T0);
    rs1_l = (rs1 == REG_RA) || (rs1 == REG_T0);
    if (uop == UOP_JAL)
        return rd_l ? 3'b100 : 3'b001;
    if (uop != UOP_JALR)
        return 3'b000;
    if (rd_l && !rs1_l)
        return 3'b100;
    if (rd_l && rs1_l)
        return (rd == rs1) ? 3'b100 : 3'b110;  // pop then push when they differ
    if (rs1_l)
        return 3'b010;
    return 3'b001;
endfunction

// {redirect, redirect pc} against the fetch prediction
function automatic logic [32:0] mispredict_redirect(input uop_t uop, input word_t pc,
                                                    input word_t a, input word_t b,
                                                    input word_t imm, input logic pred_taken,
                                                    input word_t pred_pc);
    logic  taken;
    word_t target;
    taken  = resolve_taken(uop, a, b);
    target = resolve_target(uop, pc, a, imm);
    if (!is_branch_uop(uop))
        return 33'd0;
    if (taken && (!pred_taken || pred_pc != target))
        return {1'b1, target};
    if (!taken && pred_taken)
        return {1'b1, pc + 32'd4};
    return 33'd0;
endfunction

function automatic word_t writeback_word(input alu_sel_t sel, input uop_t uop, input word_t pc,
                                         input word_t a, input word_t b, input word_t imm);
    if (sel == SEL_ALU)
        return alu_result_of(uop, pc, a, b, imm);
    if (sel == SEL_LINK)
        return pc + 32'd4;
    return 32'd0;
endfunction

function automatic word_t effective_addr(input uop_t uop, input word_t a, input word_t imm);
    if (uop inside {UOP_LB, UOP_LBU, UOP_LH, UOP_LHU, UOP_LW, UOP_SB, UOP_SH, UOP_SW})
        return a + imm;
    return 32'd0;
endfunction

function automatic word_t store_word(input uop_t uop, input word_t b);
    return (uop inside {UOP_SB, UOP_SH, UOP_SW}) ? b : 32'd0;
endfunction

`endif

//--- dv/ex_stage_tb.sv
`timescale 1ns/100ps

module ex_stage_tb;
    import rv_isa_pkg::*;
    import ex_uop_pkg::*;

    `include "ex_tb_model.svh"

    localparam int NUM_INSNS    = 2000;
    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 5;
    // at most one idle cycle per instruction plus reset and drain
    localparam int RUN_CYCLES   = NUM_INSNS * 2 + RESET_CYCLES + 10;

    logic      clk_i;
    logic      rst_n_i;
    logic      valid_i;
    word_t     pc_i;
    word_t     rs1_d_i;
    word_t     rs2_d_i;
    word_t     imm_i;
    word_t     next_pc_i;
    uop_t      uop_i;
    alu_sel_t  alu_sel_i;
    reg_addr_t rs1_a_i;
    reg_addr_t rd_a_i;
    logic      rd_we_i;
    logic      next_taken_i;

    logic      valid_o;
    logic      rd_we_o;
    logic      branch_request_o;
    logic      branch_taken_o;
    logic      branch_call_o;
    logic      branch_ret_o;
    logic      branch_jmp_o;
    logic      redirect_o;
    word_t     pc_o;
    word_t     rd_wd_o;
    word_t     mem_a_o;
    word_t     mem_wd_o;
    word_t     branch_target_o;
    word_t     redirect_pc_o;
    reg_addr_t rd_a_o;
    uop_t      uop_o;

    logic [31:0] lfsr_state;

    // control expectations cleared by reset
    logic       exp_valid_q;
    logic       exp_rd_we_q;
    logic       exp_request_q;
    logic       exp_taken_q;
    logic [2:0] exp_ras_q;  // call, ret, jmp
    logic       exp_redirect_q;

    // data expectations hold across gaps like the DUT
    logic       have_data_q;
    word_t      exp_pc_q;
    word_t      exp_rd_wd_q;
    word_t      exp_mem_a_q;
    word_t      exp_mem_wd_q;
    word_t      exp_target_q;
    word_t      exp_redirect_pc_q;
    reg_addr_t  exp_rd_a_q;
    uop_t       exp_uop_q;

    uop_t uop_table [37] = '{
        UOP_ADD, UOP_ADDI, UOP_SUB, UOP_AND, UOP_ANDI, UOP_OR, UOP_ORI, UOP_XOR, UOP_XORI,
        UOP_SLT, UOP_SLTI, UOP_SLTU, UOP_SLTIU, UOP_LUI, UOP_AUIPC,
        UOP_SLL, UOP_SLLI, UOP_SRL, UOP_SRLI, UOP_SRA, UOP_SRAI,
        UOP_JAL, UOP_JALR, UOP_BEQ, UOP_BNE, UOP_BLT, UOP_BGE, UOP_BLTU, UOP_BGEU,
        UOP_LB, UOP_LBU, UOP_LH, UOP_LHU, UOP_LW, UOP_SB, UOP_SH, UOP_SW
    };

    ex_stage ex_stage_i (.*);

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[31]};
        end
        return v;
    endfunction

    // link registers and x0 show up far more often than chance
    function automatic reg_addr_t pick_reg();
        case (rand_bits(2))
            32'd0:   return 5'd0;
            32'd1:   return REG_RA;
            32'd2:   return REG_T0;
            default: return reg_addr_t'(rand_bits(5));
        endcase
    endfunction

    function automatic alu_sel_t natural_sel(input uop_t uop);
        if (uop == UOP_JAL || uop == UOP_JALR)
            return SEL_LINK;
        if (uop >= UOP_ADD && uop <= UOP_SRAI)  // alu and shift codes are contiguous
            return SEL_ALU;
        return SEL_NONE;
    endfunction

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic value_error(input string name, input word_t expected, input word_t actual);
        fail_run($sformatf("error %s: expected 0x%h, got 0x%h", name, expected, actual));
    endtask

    task automatic drive_insn();
        uop_t uop;
        uop = uop_table[rand_bits(6) % 37];
        uop_i   = uop;
        rs1_d_i = rand_bits(32);
        if (rand_bits(2) == 0)
            rs2_d_i = rs1_d_i;  // equal operands for beq, bne, bge
        else
            rs2_d_i = rand_bits(32);
        imm_i     = rand_bits(32);
        pc_i      = rand_bits(30) << 2;
        alu_sel_i = natural_sel(uop);
        if (rand_bits(3) == 0)
            alu_sel_i = alu_sel_t'(rand_bits(3));
        rs1_a_i      = pick_reg();
        rd_a_i       = pick_reg();
        rd_we_i      = rand_bits(1) != 0;
        next_taken_i = rand_bits(1) != 0;
        if (rand_bits(1))
            next_pc_i = resolve_target(uop, pc_i, rs1_d_i, imm_i);
        else
            next_pc_i = rand_bits(30) << 2;
        valid_i = 1'b1;
    endtask

    // junk on every input so that any leak past the strobe shows up
    task automatic drive_idle();
        valid_i      = 1'b0;
        uop_i        = uop_table[rand_bits(6) % 37];
        rs1_d_i      = rand_bits(32);
        rs2_d_i      = rand_bits(32);
        imm_i        = rand_bits(32);
        pc_i         = rand_bits(32);
        alu_sel_i    = alu_sel_t'(rand_bits(3));
        rs1_a_i      = pick_reg();
        rd_a_i       = pick_reg();
        rd_we_i      = rand_bits(1) != 0;
        next_taken_i = rand_bits(1) != 0;
        next_pc_i    = rand_bits(32);
    endtask

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    initial begin
        #(RUN_CYCLES * CLK_PERIOD);
        fail_run("timeout: the instruction stream did not finish in time");
    end

    always @(posedge clk_i or negedge rst_n_i) begin : expect_update
        logic [32:0] redir;
        if (!rst_n_i) begin
            exp_valid_q    <= 1'b0;
            exp_rd_we_q    <= 1'b0;
            exp_request_q  <= 1'b0;
            exp_taken_q    <= 1'b0;
            exp_ras_q      <= 3'b000;
            exp_redirect_q <= 1'b0;
            have_data_q    <= 1'b0;
        end else begin
            redir = mispredict_redirect(uop_i, pc_i, rs1_d_i, rs2_d_i, imm_i,
                                        next_taken_i, next_pc_i);
            exp_valid_q    <= valid_i;
            exp_rd_we_q    <= valid_i & rd_we_i;
            exp_request_q  <= valid_i & is_branch_uop(uop_i);
            exp_taken_q    <= valid_i & resolve_taken(uop_i, rs1_d_i, rs2_d_i);
            exp_ras_q      <= valid_i ? classify_ras(uop_i, rd_a_i, rs1_a_i) : 3'b000;
            exp_redirect_q <= valid_i & redir[32];
            if (valid_i) begin
                have_data_q       <= 1'b1;
                exp_pc_q          <= pc_i;
                exp_rd_a_q        <= rd_a_i;
                exp_uop_q         <= uop_i;
                exp_rd_wd_q       <= writeback_word(alu_sel_i, uop_i, pc_i, rs1_d_i, rs2_d_i,
                                                    imm_i);
                exp_mem_a_q       <= effective_addr(uop_i, rs1_d_i, imm_i);
                exp_mem_wd_q      <= store_word(uop_i, rs2_d_i);
                exp_target_q      <= resolve_target(uop_i, pc_i, rs1_d_i, imm_i);
                exp_redirect_pc_q <= redir[31:0];
            end
        end
    end

    a_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i) valid_o == exp_valid_q)
        else value_error("valid_o", $sampled(exp_valid_q), $sampled(valid_o));
    a_rd_we: assert property (@(posedge clk_i) disable iff (!rst_n_i) rd_we_o == exp_rd_we_q)
        else value_error("rd_we_o", $sampled(exp_rd_we_q), $sampled(rd_we_o));
    a_request: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                                branch_request_o == exp_request_q)
        else value_error("branch_request_o", $sampled(exp_request_q), $sampled(branch_request_o));
    a_taken: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                              branch_taken_o == exp_taken_q)
        else value_error("branch_taken_o", $sampled(exp_taken_q), $sampled(branch_taken_o));
    a_ras: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                            {branch_call_o, branch_ret_o, branch_jmp_o} == exp_ras_q)
        else value_error("branch_call_o/ret_o/jmp_o", $sampled(exp_ras_q),
                         $sampled({branch_call_o, branch_ret_o, branch_jmp_o}));
    a_redirect: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                                 redirect_o == exp_redirect_q)
        else value_error("redirect_o", $sampled(exp_redirect_q), $sampled(redirect_o));
    a_quiet: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                              !valid_o |-> !(redirect_o || branch_request_o))
        else fail_run("redirect_o or branch_request_o is high while valid_o is low");

    a_pc: assert property (@(posedge clk_i) have_data_q |-> pc_o == exp_pc_q)
        else value_error("pc_o", $sampled(exp_pc_q), $sampled(pc_o));
    a_rd_a: assert property (@(posedge clk_i) have_data_q |-> rd_a_o == exp_rd_a_q)
        else value_error("rd_a_o", $sampled(exp_rd_a_q), $sampled(rd_a_o));
    a_uop: assert property (@(posedge clk_i) have_data_q |-> uop_o == exp_uop_q)
        else value_error("uop_o", $sampled(exp_uop_q), $sampled(uop_o));
    a_rd_wd: assert property (@(posedge clk_i) have_data_q |-> rd_wd_o == exp_rd_wd_q)
        else value_error("rd_wd_o", $sampled(exp_rd_wd_q), $sampled(rd_wd_o));
    a_mem_a: assert property (@(posedge clk_i) have_data_q |-> mem_a_o == exp_mem_a_q)
        else value_error("mem_a_o", $sampled(exp_mem_a_q), $sampled(mem_a_o));
    a_mem_wd: assert property (@(posedge clk_i) have_data_q |-> mem_wd_o == exp_mem_wd_q)
        else value_error("mem_wd_o", $sampled(exp_mem_wd_q), $sampled(mem_wd_o));
    a_target: assert property (@(posedge clk_i) have_data_q |-> branch_target_o == exp_target_q)
        else value_error("branch_target_o", $sampled(exp_target_q), $sampled(branch_target_o));
    a_redir_pc: assert property (@(posedge clk_i)
                                 have_data_q |-> redirect_pc_o == exp_redirect_pc_q)
        else value_error("redirect_pc_o", $sampled(exp_redirect_pc_q), $sampled(redirect_pc_o));

    initial begin
        lfsr_state   = 32'h4cbc_b686;
        rst_n_i      = 1'b0;
        valid_i      = 1'b0;
        pc_i         = '0;
        rs1_d_i      = '0;
        rs2_d_i      = '0;
        imm_i        = '0;
        next_pc_i    = '0;
        uop_i        = UOP_ADD;
        alu_sel_i    = SEL_NONE;
        rs1_a_i      = '0;
        rd_a_i       = '0;
        rd_we_i      = 1'b0;
        next_taken_i = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk_i);
        assert (!valid_o && !rd_we_o && !branch_request_o && !branch_taken_o &&
                !branch_call_o && !branch_ret_o && !branch_jmp_o && !redirect_o)
            else fail_run("control outputs are not low during reset");
        rst_n_i = 1'b1;

        for (int n = 0; n < NUM_INSNS; n++) begin
            @(negedge clk_i);
            drive_insn();
            if (rand_bits(2) == 0) begin  // one gap in four
                @(negedge clk_i);
                drive_idle();
            end
        end
        @(negedge clk_i);
        drive_idle();
        repeat (3) @(negedge clk_i);  // let the last result get checked
        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- rv_ex.f
+incdir+dv
source/rv_isa_pkg.sv
source/ex_uop_pkg.sv
source/ex_int_alu.sv
source/ex_branch_unit.sv
source/ex_result_stage.sv
source/ex_stage.sv
dv/ex_stage_tb.sv

//--- source/ex_branch_unit.sv
`timescale 1ns/100ps

module ex_branch_unit (
    input  ex_uop_pkg::uop_t      uop_i,
    input  rv_isa_pkg::word_t     pc_i,
    input  rv_isa_pkg::word_t     rs1_d_i,
    input  rv_isa_pkg::word_t     rs2_d_i,
    input  rv_isa_pkg::word_t     imm_i,
    input  rv_isa_pkg::word_t     next_pc_i,
    input  rv_isa_pkg::reg_addr_t rs1_a_i,
    input  rv_isa_pkg::reg_addr_t rd_a_i,
    input  logic                  next_taken_i,
    output logic                  request_o,
    output logic                  taken_o,
    output logic                  call_o,
    output logic                  ret_o,
    output logic                  jmp_o,
    output logic                  redirect_o,
    output rv_isa_pkg::word_t     target_o,
    output rv_isa_pkg::word_t     link_o,
    output rv_isa_pkg::word_t     redirect_pc_o
);
    import rv_isa_pkg::*;
    import ex_uop_pkg::*;

    word_t pc_add_imm;
    word_t rs1_add_imm;
    logic  rs1_eq_rs2;
    logic  rs1_lt_rs2;
    logic  rs1_ltu_rs2;
    logic  rd_link;
    logic  rs1_link;

    function automatic logic is_link_reg(input reg_addr_t a);
        return (a == REG_RA) || (a == REG_T0);
    endfunction

    assign pc_add_imm  = pc_i + imm_i;
    assign rs1_add_imm = rs1_d_i + imm_i;
    assign link_o      = pc_i + INSN_BYTES;  // also the fall-through pc

    assign rs1_eq_rs2  = rs1_d_i == rs2_d_i;
    assign rs1_lt_rs2  = $signed(rs1_d_i) < $signed(rs2_d_i);
    assign rs1_ltu_rs2 = rs1_d_i < rs2_d_i;

    assign rd_link  = is_link_reg(rd_a_i);
    assign rs1_link = is_link_reg(rs1_a_i);

    always_comb begin
        request_o     = 1'b0;
        taken_o       = 1'b0;
        call_o        = 1'b0;
        ret_o         = 1'b0;
        jmp_o         = 1'b0;
        target_o      = '0;
        redirect_o    = 1'b0;
        redirect_pc_o = '0;

        case (uop_i)
            UOP_JAL: begin
                request_o = 1'b1;
                taken_o   = 1'b1;
                target_o  = pc_add_imm;
                call_o    = rd_link;   // push only when writing a link reg
                jmp_o     = !rd_link;
            end
            UOP_JALR: begin
                request_o = 1'b1;
                taken_o   = 1'b1;
                target_o  = rs1_add_imm;
                // RAS hint table of the ISA manual
                // rd link pushes, rs1 link pops unless it is the same reg as rd
                call_o    = rd_link;
                ret_o     = rs1_link && (!rd_link || (rd_a_i != rs1_a_i));
                jmp_o     = !rd_link && !rs1_link;
            end
            UOP_BEQ, UOP_BNE, UOP_BLT, UOP_BGE, UOP_BLTU, UOP_BGEU: begin
                request_o = 1'b1;
                target_o  = pc_add_imm;
                case (uop_i)
                    UOP_BEQ:  taken_o = rs1_eq_rs2;
                    UOP_BNE:  taken_o = !rs1_eq_rs2;
                    UOP_BLT:  taken_o = rs1_lt_rs2;
                    UOP_BGE:  taken_o = !rs1_lt_rs2;
                    UOP_BLTU: taken_o = rs1_ltu_rs2;
                    default:  taken_o = !rs1_ltu_rs2;  // bgeu
                endcase
            end
            default: begin
            end
        endcase

        // compare the resolved outcome with the fetch prediction
        if (request_o) begin
            if (taken_o) begin
                if (!next_taken_i || (next_pc_i != target_o)) begin
                    redirect_o    = 1'b1;
                    redirect_pc_o = target_o;
                end
            end else if (next_taken_i) begin
                redirect_o    = 1'b1;  // predicted taken, fell through
                redirect_pc_o = link_o;
            end
        end
    end

endmodule

//--- source/ex_int_alu.sv
`timescale 1ns/100ps

module ex_int_alu (
    input  ex_uop_pkg::uop_t  uop_i,
    input  rv_isa_pkg::word_t pc_i,
    input  rv_isa_pkg::word_t rs1_d_i,
    input  rv_isa_pkg::word_t rs2_d_i,
    input  rv_isa_pkg::word_t imm_i,
    output rv_isa_pkg::word_t alu_result_o
);
    import rv_isa_pkg::*;
    import ex_uop_pkg::*;

    word_t  rs1_add_rs2;
    word_t  rs1_sub_rs2;
    word_t  rs1_add_imm;
    word_t  pc_add_imm;

    logic   lt_rs2;    // signed compares
    logic   lt_imm;
    logic   ltu_rs2;   // unsigned compares
    logic   ltu_imm;

    shamt_t shamt_reg;
    shamt_t shamt_imm;

    word_t  sll_reg;
    word_t  srl_reg;
    word_t  sra_reg;
    word_t  sll_imm;
    word_t  srl_imm;
    word_t  sra_imm;

    assign rs1_add_rs2 = rs1_d_i + rs2_d_i;
    assign rs1_sub_rs2 = rs1_d_i - rs2_d_i;
    assign rs1_add_imm = rs1_d_i + imm_i;
    assign pc_add_imm  = pc_i + imm_i;

    assign lt_rs2  = $signed(rs1_d_i) < $signed(rs2_d_i);
    assign lt_imm  = $signed(rs1_d_i) < $signed(imm_i);
    assign ltu_rs2 = rs1_d_i < rs2_d_i;
    assign ltu_imm = rs1_d_i < imm_i;

    // only the low five bits count on RV32
    assign shamt_reg = rs2_d_i[4:0];
    assign shamt_imm = imm_i[4:0];

    assign sll_reg = rs1_d_i << shamt_reg;
    assign srl_reg = rs1_d_i >> shamt_reg;
    assign sra_reg = word_t'($signed(rs1_d_i) >>> shamt_reg);  // sign fill
    assign sll_imm = rs1_d_i << shamt_imm;
    assign srl_imm = rs1_d_i >> shamt_imm;
    assign sra_imm = word_t'($signed(rs1_d_i) >>> shamt_imm);

    always_comb begin
        case (uop_i)
            UOP_ADD:   alu_result_o = rs1_add_rs2;
            UOP_ADDI:  alu_result_o = rs1_add_imm;
            UOP_SUB:   alu_result_o = rs1_sub_rs2;

            UOP_AND:   alu_result_o = rs1_d_i & rs2_d_i;
            UOP_ANDI:  alu_result_o = rs1_d_i & imm_i;
            UOP_OR:    alu_result_o = rs1_d_i | rs2_d_i;
            UOP_ORI:   alu_result_o = rs1_d_i | imm_i;
            UOP_XOR:   alu_result_o = rs1_d_i ^ rs2_d_i;
            UOP_XORI:  alu_result_o = rs1_d_i ^ imm_i;

            // compare flag zero extended to a word
            UOP_SLT:   alu_result_o = {{(XLEN-1){1'b0}}, lt_rs2};
            UOP_SLTI:  alu_result_o = {{(XLEN-1){1'b0}}, lt_imm};
            UOP_SLTU:  alu_result_o = {{(XLEN-1){1'b0}}, ltu_rs2};
            UOP_SLTIU: alu_result_o = {{(XLEN-1){1'b0}}, ltu_imm};

            UOP_LUI:   alu_result_o = imm_i;
            UOP_AUIPC: alu_result_o = pc_add_imm;

            UOP_SLL:   alu_result_o = sll_reg;
            UOP_SLLI:  alu_result_o = sll_imm;
            UOP_SRL:   alu_result_o = srl_reg;
            UOP_SRLI:  alu_result_o = srl_imm;
            UOP_SRA:   alu_result_o = sra_reg;
            UOP_SRAI:  alu_result_o = sra_imm;

            default:   alu_result_o = '0;  // branches, memory ops
        endcase
    end

endmodule

//--- source/ex_result_stage.sv
`timescale 1ns/100ps

module ex_result_stage (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  valid_i,
    input  ex_uop_pkg::uop_t      uop_i,
    input  ex_uop_pkg::alu_sel_t  alu_sel_i,
    input  rv_isa_pkg::word_t     pc_i,
    input  rv_isa_pkg::word_t     rs1_d_i,
    input  rv_isa_pkg::word_t     rs2_d_i,
    input  rv_isa_pkg::word_t     imm_i,
    input  rv_isa_pkg::word_t     alu_result_i,
    input  rv_isa_pkg::word_t     link_i,
    input  logic                  rd_we_i,
    input  rv_isa_pkg::reg_addr_t rd_a_i,
    input  logic                  request_i,
    input  logic                  taken_i,
    input  logic                  call_i,
    input  logic                  ret_i,
    input  logic                  jmp_i,
    input  logic                  redirect_i,
    input  rv_isa_pkg::word_t     target_i,
    input  rv_isa_pkg::word_t     redirect_pc_i,
    output logic                  valid_o,
    output logic                  rd_we_o,
    output logic                  branch_request_o,
    output logic                  branch_taken_o,
    output logic                  branch_call_o,
    output logic                  branch_ret_o,
    output logic                  branch_jmp_o,
    output logic                  redirect_o,
    output rv_isa_pkg::word_t     pc_o,
    output rv_isa_pkg::word_t     rd_wd_o,
    output rv_isa_pkg::word_t     mem_a_o,
    output rv_isa_pkg::word_t     mem_wd_o,
    output rv_isa_pkg::word_t     branch_target_o,
    output rv_isa_pkg::word_t     redirect_pc_o,
    output rv_isa_pkg::reg_addr_t rd_a_o,
    output ex_uop_pkg::uop_t      uop_o
);
    import rv_isa_pkg::*;
    import ex_uop_pkg::*;

    word_t rd_wd;
    word_t mem_a;
    word_t mem_wd;
    logic  is_load;
    logic  is_store;

    assign is_load  = (uop_i == UOP_LB) || (uop_i == UOP_LBU) || (uop_i == UOP_LH) ||
                      (uop_i == UOP_LHU) || (uop_i == UOP_LW);
    assign is_store = (uop_i == UOP_SB) || (uop_i == UOP_SH) || (uop_i == UOP_SW);

    // effective address and store data for the LSU
    assign mem_a  = (is_load || is_store) ? rs1_d_i + imm_i : '0;
    assign mem_wd = is_store ? rs2_d_i : '0;

    always_comb begin
        case (alu_sel_i)
            SEL_ALU:  rd_wd = alu_result_i;
            SEL_LINK: rd_wd = link_i;
            SEL_NONE: rd_wd = '0;
            default:  rd_wd = '0;
        endcase
    end

    // control side, nothing fires without the strobe
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o          <= 1'b0;
            rd_we_o          <= 1'b0;
            branch_request_o <= 1'b0;
            branch_taken_o   <= 1'b0;
            branch_call_o    <= 1'b0;
            branch_ret_o     <= 1'b0;
            branch_jmp_o     <= 1'b0;
            redirect_o       <= 1'b0;
        end else begin
            valid_o          <= valid_i;
            rd_we_o          <= valid_i & rd_we_i;
            branch_request_o <= valid_i & request_i;
            branch_taken_o   <= valid_i & taken_i;
            branch_call_o    <= valid_i & call_i;
            branch_ret_o     <= valid_i & ret_i;
            branch_jmp_o     <= valid_i & jmp_i;
            redirect_o       <= valid_i & redirect_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin  // data holds across gaps
            pc_o            <= pc_i;
            rd_a_o          <= rd_a_i;
            uop_o           <= uop_i;
            rd_wd_o         <= rd_wd;
            mem_a_o         <= mem_a;
            mem_wd_o        <= mem_wd;
            branch_target_o <= target_i;
            redirect_pc_o   <= redirect_pc_i;
        end
    end

endmodule

//--- source/ex_stage.sv
`timescale 1ns/100ps

module ex_stage (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  valid_i,
    input  rv_isa_pkg::word_t     pc_i,
    input  rv_isa_pkg::word_t     rs1_d_i,
    input  rv_isa_pkg::word_t     rs2_d_i,
    input  rv_isa_pkg::word_t     imm_i,
    input  rv_isa_pkg::word_t     next_pc_i,
    input  ex_uop_pkg::uop_t      uop_i,
    input  ex_uop_pkg::alu_sel_t  alu_sel_i,
    input  rv_isa_pkg::reg_addr_t rs1_a_i,
    input  rv_isa_pkg::reg_addr_t rd_a_i,
    input  logic                  rd_we_i,
    input  logic                  next_taken_i,
    output logic                  valid_o,
    output logic                  rd_we_o,
    output logic                  branch_request_o,
    output logic                  branch_taken_o,
    output logic                  branch_call_o,
    output logic                  branch_ret_o,
    output logic                  branch_jmp_o,
    output logic                  redirect_o,
    output rv_isa_pkg::word_t     pc_o,
    output rv_isa_pkg::word_t     rd_wd_o,
    output rv_isa_pkg::word_t     mem_a_o,
    output rv_isa_pkg::word_t     mem_wd_o,
    output rv_isa_pkg::word_t     branch_target_o,
    output rv_isa_pkg::word_t     redirect_pc_o,
    output rv_isa_pkg::reg_addr_t rd_a_o,
    output ex_uop_pkg::uop_t      uop_o
);
    import rv_isa_pkg::*;

    word_t alu_result;
    word_t br_target;
    word_t br_link;
    word_t br_redirect_pc;
    logic  br_request;
    logic  br_taken;
    logic  br_call;
    logic  br_ret;
    logic  br_jmp;
    logic  br_redirect;  // raw, gated by the strobe in the result stage

    ex_int_alu ex_int_alu_i (
        .uop_i        (uop_i),
        .pc_i         (pc_i),
        .rs1_d_i      (rs1_d_i),
        .rs2_d_i      (rs2_d_i),
        .imm_i        (imm_i),
        .alu_result_o (alu_result)
    );

    ex_branch_unit ex_branch_unit_i (
        .uop_i         (uop_i),
        .pc_i          (pc_i),
        .rs1_d_i       (rs1_d_i),
        .rs2_d_i       (rs2_d_i),
        .imm_i         (imm_i),
        .next_pc_i     (next_pc_i),
        .rs1_a_i       (rs1_a_i),
        .rd_a_i        (rd_a_i),
        .next_taken_i  (next_taken_i),
        .request_o     (br_request),
        .taken_o       (br_taken),
        .call_o        (br_call),
        .ret_o         (br_ret),
        .jmp_o         (br_jmp),
        .redirect_o    (br_redirect),
        .target_o      (br_target),
        .link_o        (br_link),
        .redirect_pc_o (br_redirect_pc)
    );

    ex_result_stage ex_result_stage_i (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .valid_i          (valid_i),
        .uop_i            (uop_i),
        .alu_sel_i        (alu_sel_i),
        .pc_i             (pc_i),
        .rs1_d_i          (rs1_d_i),
        .rs2_d_i          (rs2_d_i),
        .imm_i            (imm_i),
        .alu_result_i     (alu_result),
        .link_i           (br_link),
        .rd_we_i          (rd_we_i),
        .rd_a_i           (rd_a_i),
        .request_i        (br_request),
        .taken_i          (br_taken),
        .call_i           (br_call),
        .ret_i            (br_ret),
        .jmp_i            (br_jmp),
        .redirect_i       (br_redirect),
        .target_i         (br_target),
        .redirect_pc_i    (br_redirect_pc),
        .valid_o          (valid_o),
        .rd_we_o          (rd_we_o),
        .branch_request_o (branch_request_o),
        .branch_taken_o   (branch_taken_o),
        .branch_call_o    (branch_call_o),
        .branch_ret_o     (branch_ret_o),
        .branch_jmp_o     (branch_jmp_o),
        .redirect_o       (redirect_o),
        .pc_o             (pc_o),
        .rd_wd_o          (rd_wd_o),
        .mem_a_o          (mem_a_o),
        .mem_wd_o         (mem_wd_o),
        .branch_target_o  (branch_target_o),
        .redirect_pc_o    (redirect_pc_o),
        .rd_a_o           (rd_a_o),
        .uop_o            (uop_o)
    );

endmodule

//--- source/ex_uop_pkg.sv
package ex_uop_pkg;

    // micro-op code from the decoder
    typedef logic [5:0] uop_t;

    // register-register and register-immediate arithmetic
    localparam uop_t UOP_ADD   = 6'd1;
    localparam uop_t UOP_ADDI  = 6'd2;
    localparam uop_t UOP_SUB   = 6'd3;

    // bitwise logic
    localparam uop_t UOP_AND   = 6'd4;
    localparam uop_t UOP_ANDI  = 6'd5;
    localparam uop_t UOP_OR    = 6'd6;
    localparam uop_t UOP_ORI   = 6'd7;
    localparam uop_t UOP_XOR   = 6'd8;
    localparam uop_t UOP_XORI  = 6'd9;

    // set-less-than, result is 0 or 1
    localparam uop_t UOP_SLT   = 6'd10;
    localparam uop_t UOP_SLTI  = 6'd11;
    localparam uop_t UOP_SLTU  = 6'd12;
    localparam uop_t UOP_SLTIU = 6'd13;

    localparam uop_t UOP_LUI   = 6'd14;  // imm already shifted by the decoder
    localparam uop_t UOP_AUIPC = 6'd15;

    // shifts
    localparam uop_t UOP_SLL   = 6'd16;
    localparam uop_t UOP_SLLI  = 6'd17;
    localparam uop_t UOP_SRL   = 6'd18;
    localparam uop_t UOP_SRLI  = 6'd19;
    localparam uop_t UOP_SRA   = 6'd20;
    localparam uop_t UOP_SRAI  = 6'd21;

    // unconditional jumps and conditional branches
    localparam uop_t UOP_JAL   = 6'd24;
    localparam uop_t UOP_JALR  = 6'd25;
    localparam uop_t UOP_BEQ   = 6'd26;
    localparam uop_t UOP_BNE   = 6'd27;
    localparam uop_t UOP_BLT   = 6'd28;
    localparam uop_t UOP_BGE   = 6'd29;
    localparam uop_t UOP_BLTU  = 6'd30;
    localparam uop_t UOP_BGEU  = 6'd31;

    // loads and stores, width handled in the LSU
    localparam uop_t UOP_LB    = 6'd32;
    localparam uop_t UOP_LBU   = 6'd33;
    localparam uop_t UOP_LH    = 6'd34;
    localparam uop_t UOP_LHU   = 6'd35;
    localparam uop_t UOP_LW    = 6'd36;
    localparam uop_t UOP_SB    = 6'd40;
    localparam uop_t UOP_SH    = 6'd41;
    localparam uop_t UOP_SW    = 6'd42;

    // which unit feeds the register write-back word
    typedef logic [2:0] alu_sel_t;

    localparam alu_sel_t SEL_NONE = 3'd0;  // stores, branches
    localparam alu_sel_t SEL_ALU  = 3'd1;
    localparam alu_sel_t SEL_LINK = 3'd2;  // jal, jalr write pc + 4

endpackage

//--- source/rv_isa_pkg.sv
package rv_isa_pkg;

    // RV32 base integer machine
    localparam int XLEN = 32;

    // one architectural data word
    typedef logic [XLEN-1:0] word_t;

    // register file index, x0 to x31
    typedef logic [4:0] reg_addr_t;

    // shift amount field of RV32I
    typedef logic [4:0] shamt_t;

    // link registers per the calling convention
    // the return-address stack keys on these two
    localparam reg_addr_t REG_RA = 5'd1;  // x1
    localparam reg_addr_t REG_T0 = 5'd5;  // x5, alternate link

    // no compressed instructions, every instruction is one word
    localparam word_t INSN_BYTES = 32'd4;

endpackage
